/* logic/uce_pkg.sv */
package uce_pkg;

  // Address layout is {tag, index, block offset}
  localparam int PADDR_WIDTH        = 20;
  localparam int DWORD_WIDTH        = 64;
  localparam int BLOCK_OFFSET_WIDTH = 3;

  localparam int SETS        = 16;
  localparam int INDEX_WIDTH = $clog2(SETS);

  localparam int ASSOC     = 2;
  localparam int WAY_WIDTH = $clog2(ASSOC);

  localparam int TAG_WIDTH = PADDR_WIDTH - INDEX_WIDTH - BLOCK_OFFSET_WIDTH;

  // One extra count bit so that a full tracker can hold MAX_CREDITS itself
  localparam int MAX_CREDITS  = 4;
  localparam int CREDIT_WIDTH = $clog2(MAX_CREDITS + 1);

  // Sizes are log2 of the byte count and a whole block is code 3
  localparam int SIZE_WIDTH = 2;
  localparam logic [SIZE_WIDTH-1:0] BLOCK_SIZE = 2'd3;

  typedef enum logic [1:0]
  {
    e_miss_load,
    e_uc_load,
    e_uc_store,
    e_cache_clear
  } cache_req_type_e;

  typedef enum logic [0:0]
  {
    e_tag_set_clear,
    e_tag_set_tag
  } tag_opcode_e;

  typedef enum logic [0:0]
  {
    e_data_write,
    e_data_uncached
  } data_opcode_e;

  typedef enum logic [1:0]
  {
    e_mem_rd,
    e_mem_uc_rd,
    e_mem_uc_wr
  } mem_msg_e;

  typedef enum logic [2:0]
  {
    e_reset,
    e_clear,
    e_ready,
    e_send,
    e_fill_wait,
    e_uc_read_wait
  } uce_state_e;

endpackage

/* logic/uce_req_regs.sv */
`timescale 1ns/1ps

module uce_req_regs
  (
    input  logic                                 clk_i,
    input  logic                                 reset_i,

    input  uce_pkg::cache_req_type_e             cache_req_type_i,
    input  logic [uce_pkg::PADDR_WIDTH-1:0]      cache_req_addr_i,
    input  logic [uce_pkg::DWORD_WIDTH-1:0]      cache_req_data_i,
    input  logic [uce_pkg::SIZE_WIDTH-1:0]       cache_req_size_i,
    input  logic                                 accept_i,
    input  logic                                 complete_i,

    input  logic [uce_pkg::WAY_WIDTH-1:0]        metadata_way_i,
    input  logic                                 metadata_v_i,

    output uce_pkg::cache_req_type_e             req_type_o,
    output logic [uce_pkg::PADDR_WIDTH-1:0]      req_addr_o,
    output logic [uce_pkg::DWORD_WIDTH-1:0]      req_data_o,
    output logic [uce_pkg::SIZE_WIDTH-1:0]       req_size_o,
    output logic                                 req_v_o,

    output logic [uce_pkg::WAY_WIDTH-1:0]        meta_way_o,
    output logic                                 meta_v_o
  );

  always_ff @(posedge clk_i)
  begin
    if (accept_i)
    begin
      req_type_o <= cache_req_type_i;
      req_addr_o <= cache_req_addr_i;
      req_data_o <= cache_req_data_i;
      req_size_o <= cache_req_size_i;
    end
    if (metadata_v_i)
      meta_way_o <= metadata_way_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      req_v_o  <= 1'b0;
      meta_v_o <= 1'b0;
    end
    else
    begin
      if (accept_i)
        req_v_o <= 1'b1;
      else if (complete_i)
        req_v_o <= 1'b0;

      // Metadata may land in the accept cycle itself, so the set has priority
      if (metadata_v_i)
        meta_v_o <= 1'b1;
      else if (accept_i)
        meta_v_o <= 1'b0;
    end
  end

endmodule

/* logic/uce_credit_tracker.sv */
`timescale 1ns/1ps

module uce_credit_tracker
  (
    input  logic clk_i,
    input  logic reset_i,

    input  logic cmd_fire_i,
    input  logic resp_fire_i,

    output logic credits_full_o,
    output logic credits_empty_o
  );

  import uce_pkg::*;

  logic [CREDIT_WIDTH-1:0] count_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      count_r <= '0;
    else if (cmd_fire_i & ~resp_fire_i)
      count_r <= count_r + 1'b1;
    else if (resp_fire_i & ~cmd_fire_i)
      count_r <= count_r - 1'b1;
  end

  assign credits_full_o  = (count_r == CREDIT_WIDTH'(MAX_CREDITS));
  assign credits_empty_o = (count_r == '0);

endmodule

/* logic/uce_fsm.sv */
`timescale 1ns/1ps

module uce_fsm
  (
    input  logic                                 clk_i,
    input  logic                                 reset_i,

    input  logic                                 cache_req_v_i,
    input  uce_pkg::cache_req_type_e             cache_req_type_i,
    output logic                                 cache_req_yumi_o,
    output logic                                 cache_req_busy_o,
    output logic                                 cache_req_complete_o,

    input  uce_pkg::cache_req_type_e             req_type_i,
    input  logic [uce_pkg::PADDR_WIDTH-1:0]      req_addr_i,
    input  logic [uce_pkg::DWORD_WIDTH-1:0]      req_data_i,
    input  logic [uce_pkg::SIZE_WIDTH-1:0]       req_size_i,
    input  logic                                 req_v_i,
    input  logic [uce_pkg::WAY_WIDTH-1:0]        meta_way_i,
    input  logic                                 meta_v_i,

    input  logic                                 credits_full_i,
    input  logic                                 credits_empty_i,

    output uce_pkg::tag_opcode_e                 tag_mem_pkt_opcode_o,
    output logic [uce_pkg::INDEX_WIDTH-1:0]      tag_mem_pkt_index_o,
    output logic [uce_pkg::WAY_WIDTH-1:0]        tag_mem_pkt_way_o,
    output logic [uce_pkg::TAG_WIDTH-1:0]        tag_mem_pkt_tag_o,
    output logic                                 tag_mem_pkt_v_o,
    input  logic                                 tag_mem_pkt_yumi_i,

    output uce_pkg::data_opcode_e                data_mem_pkt_opcode_o,
    output logic [uce_pkg::INDEX_WIDTH-1:0]      data_mem_pkt_index_o,
    output logic [uce_pkg::WAY_WIDTH-1:0]        data_mem_pkt_way_o,
    output logic [uce_pkg::DWORD_WIDTH-1:0]      data_mem_pkt_data_o,
    output logic                                 data_mem_pkt_v_o,
    input  logic                                 data_mem_pkt_yumi_i,

    output uce_pkg::mem_msg_e                    mem_cmd_type_o,
    output logic [uce_pkg::PADDR_WIDTH-1:0]      mem_cmd_addr_o,
    output logic [uce_pkg::SIZE_WIDTH-1:0]       mem_cmd_size_o,
    output logic [uce_pkg::WAY_WIDTH-1:0]        mem_cmd_way_o,
    output logic [uce_pkg::DWORD_WIDTH-1:0]      mem_cmd_data_o,
    output logic                                 mem_cmd_v_o,
    input  logic                                 mem_cmd_yumi_i,

    input  uce_pkg::mem_msg_e                    mem_resp_type_i,
    input  logic [uce_pkg::PADDR_WIDTH-1:0]      mem_resp_addr_i,
    input  logic [uce_pkg::WAY_WIDTH-1:0]        mem_resp_way_i,
    input  logic [uce_pkg::DWORD_WIDTH-1:0]      mem_resp_data_i,
    input  logic                                 mem_resp_v_i,
    output logic                                 mem_resp_yumi_o,

    output logic                                 cmd_fire_o,
    output logic                                 resp_fire_o
  );

  import uce_pkg::*;

  uce_state_e state_r, state_n;

  logic [INDEX_WIDTH-1:0] index_r;
  logic index_up;
  logic index_done;

  // Tag and data writes of a fill may be accepted in different cycles
  logic tag_done_r;
  logic data_done_r;

  logic store_resp_v;
  logic load_resp_v;
  logic load_resp_yumi;

  assign index_done = (index_r == INDEX_WIDTH'(SETS - 1));

  // Store responses carry nothing for the cache and are taken at once
  assign store_resp_v = mem_resp_v_i & (mem_resp_type_i == e_mem_uc_wr);
  assign load_resp_v  = mem_resp_v_i & (mem_resp_type_i != e_mem_uc_wr);

  assign mem_resp_yumi_o  = store_resp_v | load_resp_yumi;
  assign resp_fire_o      = mem_resp_v_i & mem_resp_yumi_o;
  assign cmd_fire_o       = mem_cmd_v_o & mem_cmd_yumi_i;
  assign cache_req_busy_o = (state_r == e_reset) | (state_r == e_clear) | credits_full_i;

  always_comb
  begin
    state_n              = state_r;
    index_up             = 1'b0;
    cache_req_yumi_o     = 1'b0;
    cache_req_complete_o = 1'b0;
    load_resp_yumi       = 1'b0;

    tag_mem_pkt_opcode_o = e_tag_set_clear;
    tag_mem_pkt_index_o  = '0;
    tag_mem_pkt_way_o    = '0;
    tag_mem_pkt_tag_o    = '0;
    tag_mem_pkt_v_o      = 1'b0;

    data_mem_pkt_opcode_o = e_data_write;
    data_mem_pkt_index_o  = '0;
    data_mem_pkt_way_o    = '0;
    data_mem_pkt_data_o   = '0;
    data_mem_pkt_v_o      = 1'b0;

    mem_cmd_type_o = e_mem_rd;
    mem_cmd_addr_o = '0;
    mem_cmd_size_o = '0;
    mem_cmd_way_o  = '0;
    mem_cmd_data_o = '0;
    mem_cmd_v_o    = 1'b0;

    case (state_r)
      e_reset:
        state_n = e_clear;
      e_clear:
      begin
        tag_mem_pkt_index_o  = index_r;
        tag_mem_pkt_v_o      = 1'b1;
        index_up             = tag_mem_pkt_yumi_i;
        cache_req_complete_o = index_up & index_done;
        if (cache_req_complete_o)
          state_n = e_ready;
      end
      e_ready:
      begin
        // A clear is held off until every outstanding store is answered
        cache_req_yumi_o = cache_req_v_i & ~req_v_i
                         & ((cache_req_type_i != e_cache_clear) | credits_empty_i);
        if (cache_req_yumi_o)
          state_n = (cache_req_type_i == e_cache_clear) ? e_clear : e_send;
      end
      e_send:
      begin
        if (req_type_i == e_miss_load)
        begin
          mem_cmd_type_o = e_mem_rd;
          mem_cmd_addr_o = {req_addr_i[PADDR_WIDTH-1:BLOCK_OFFSET_WIDTH],
                            BLOCK_OFFSET_WIDTH'(0)};
          mem_cmd_size_o = BLOCK_SIZE;
          mem_cmd_way_o  = meta_way_i;
          mem_cmd_v_o    = req_v_i & meta_v_i & ~credits_full_i;
          if (mem_cmd_v_o & mem_cmd_yumi_i)
            state_n = e_fill_wait;
        end
        else
        begin
          mem_cmd_type_o = (req_type_i == e_uc_load) ? e_mem_uc_rd : e_mem_uc_wr;
          mem_cmd_addr_o = req_addr_i;
          mem_cmd_size_o = req_size_i;
          mem_cmd_data_o = req_data_i;
          mem_cmd_v_o    = req_v_i & ~credits_full_i;
          cache_req_complete_o = mem_cmd_v_o & mem_cmd_yumi_i & (req_type_i == e_uc_store);
          if (mem_cmd_v_o & mem_cmd_yumi_i)
            state_n = (req_type_i == e_uc_store) ? e_ready : e_uc_read_wait;
        end
      end
      e_fill_wait:
      begin
        tag_mem_pkt_opcode_o = e_tag_set_tag;
        tag_mem_pkt_index_o  = mem_resp_addr_i[BLOCK_OFFSET_WIDTH+:INDEX_WIDTH];
        tag_mem_pkt_way_o    = mem_resp_way_i;
        tag_mem_pkt_tag_o    = mem_resp_addr_i[PADDR_WIDTH-1-:TAG_WIDTH];
        tag_mem_pkt_v_o      = load_resp_v & ~tag_done_r;

        data_mem_pkt_opcode_o = e_data_write;
        data_mem_pkt_index_o  = mem_resp_addr_i[BLOCK_OFFSET_WIDTH+:INDEX_WIDTH];
        data_mem_pkt_way_o    = mem_resp_way_i;
        data_mem_pkt_data_o   = mem_resp_data_i;
        data_mem_pkt_v_o      = load_resp_v & ~data_done_r;

        load_resp_yumi = (tag_done_r | (tag_mem_pkt_v_o & tag_mem_pkt_yumi_i))
                       & (data_done_r | (data_mem_pkt_v_o & data_mem_pkt_yumi_i));
        cache_req_complete_o = load_resp_yumi;
        if (load_resp_yumi)
          state_n = e_ready;
      end
      e_uc_read_wait:
      begin
        data_mem_pkt_opcode_o = e_data_uncached;
        data_mem_pkt_index_o  = mem_resp_addr_i[BLOCK_OFFSET_WIDTH+:INDEX_WIDTH];
        data_mem_pkt_data_o   = mem_resp_data_i;
        data_mem_pkt_v_o      = load_resp_v;
        load_resp_yumi        = data_mem_pkt_v_o & data_mem_pkt_yumi_i;
        cache_req_complete_o  = load_resp_yumi;
        if (load_resp_yumi)
          state_n = e_ready;
      end
      default:
        state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r     <= e_reset;
      index_r     <= '0;
      tag_done_r  <= 1'b0;
      data_done_r <= 1'b0;
    end
    else
    begin
      state_r <= state_n;
      if (index_up)
        index_r <= index_done ? '0 : index_r + 1'b1;
      if (load_resp_yumi)
      begin
        tag_done_r  <= 1'b0;
        data_done_r <= 1'b0;
      end
      else if (state_r == e_fill_wait)
      begin
        tag_done_r  <= tag_done_r | (tag_mem_pkt_v_o & tag_mem_pkt_yumi_i);
        data_done_r <= data_done_r | (data_mem_pkt_v_o & data_mem_pkt_yumi_i);
      end
    end
  end

endmodule

/* logic/uce_top.sv */
`timescale 1ns/1ps

module uce_top
  (
    input  logic                                 clk_i,
    input  logic                                 reset_i,

    input  uce_pkg::cache_req_type_e             cache_req_type_i,
    input  logic [uce_pkg::PADDR_WIDTH-1:0]      cache_req_addr_i,
    input  logic [uce_pkg::DWORD_WIDTH-1:0]      cache_req_data_i,
    input  logic [uce_pkg::SIZE_WIDTH-1:0]       cache_req_size_i,
    input  logic                                 cache_req_v_i,
    output logic                                 cache_req_yumi_o,
    output logic                                 cache_req_busy_o,
    output logic                                 cache_req_complete_o,
    input  logic [uce_pkg::WAY_WIDTH-1:0]        cache_req_metadata_way_i,
    input  logic                                 cache_req_metadata_v_i,
    output logic                                 cache_req_credits_full_o,
    output logic                                 cache_req_credits_empty_o,

    output uce_pkg::tag_opcode_e                 tag_mem_pkt_opcode_o,
    output logic [uce_pkg::INDEX_WIDTH-1:0]      tag_mem_pkt_index_o,
    output logic [uce_pkg::WAY_WIDTH-1:0]        tag_mem_pkt_way_o,
    output logic [uce_pkg::TAG_WIDTH-1:0]        tag_mem_pkt_tag_o,
    output logic                                 tag_mem_pkt_v_o,
    input  logic                                 tag_mem_pkt_yumi_i,

    output uce_pkg::data_opcode_e                data_mem_pkt_opcode_o,
    output logic [uce_pkg::INDEX_WIDTH-1:0]      data_mem_pkt_index_o,
    output logic [uce_pkg::WAY_WIDTH-1:0]        data_mem_pkt_way_o,
    output logic [uce_pkg::DWORD_WIDTH-1:0]      data_mem_pkt_data_o,
    output logic                                 data_mem_pkt_v_o,
    input  logic                                 data_mem_pkt_yumi_i,

    output uce_pkg::mem_msg_e                    mem_cmd_type_o,
    output logic [uce_pkg::PADDR_WIDTH-1:0]      mem_cmd_addr_o,
    output logic [uce_pkg::SIZE_WIDTH-1:0]       mem_cmd_size_o,
    output logic [uce_pkg::WAY_WIDTH-1:0]        mem_cmd_way_o,
    output logic [uce_pkg::DWORD_WIDTH-1:0]      mem_cmd_data_o,
    output logic                                 mem_cmd_v_o,
    input  logic                                 mem_cmd_yumi_i,

    input  uce_pkg::mem_msg_e                    mem_resp_type_i,
    input  logic [uce_pkg::PADDR_WIDTH-1:0]      mem_resp_addr_i,
    input  logic [uce_pkg::WAY_WIDTH-1:0]        mem_resp_way_i,
    input  logic [uce_pkg::DWORD_WIDTH-1:0]      mem_resp_data_i,
    input  logic                                 mem_resp_v_i,
    output logic                                 mem_resp_yumi_o
  );

  import uce_pkg::*;

  cache_req_type_e         req_type;
  logic [PADDR_WIDTH-1:0]  req_addr;
  logic [DWORD_WIDTH-1:0]  req_data;
  logic [SIZE_WIDTH-1:0]   req_size;
  logic                    req_v;
  logic [WAY_WIDTH-1:0]    meta_way;
  logic                    meta_v;
  logic                    cmd_fire;
  logic                    resp_fire;

  uce_req_regs req_regs
    (
      .clk_i            (clk_i),
      .reset_i          (reset_i),
      .cache_req_type_i (cache_req_type_i),
      .cache_req_addr_i (cache_req_addr_i),
      .cache_req_data_i (cache_req_data_i),
      .cache_req_size_i (cache_req_size_i),
      .accept_i         (cache_req_yumi_o),
      .complete_i       (cache_req_complete_o),
      .metadata_way_i   (cache_req_metadata_way_i),
      .metadata_v_i     (cache_req_metadata_v_i),
      .req_type_o       (req_type),
      .req_addr_o       (req_addr),
      .req_data_o       (req_data),
      .req_size_o       (req_size),
      .req_v_o          (req_v),
      .meta_way_o       (meta_way),
      .meta_v_o         (meta_v)
    );

  uce_credit_tracker credit_tracker
    (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .cmd_fire_i      (cmd_fire),
      .resp_fire_i     (resp_fire),
      .credits_full_o  (cache_req_credits_full_o),
      .credits_empty_o (cache_req_credits_empty_o)
    );

  uce_fsm fsm
    (
      .clk_i, .reset_i,
      .cache_req_v_i, .cache_req_type_i,
      .cache_req_yumi_o, .cache_req_busy_o, .cache_req_complete_o,
      .req_type_i (req_type), .req_addr_i (req_addr), .req_data_i (req_data),
      .req_size_i (req_size), .req_v_i (req_v),
      .meta_way_i (meta_way), .meta_v_i (meta_v),
      .credits_full_i  (cache_req_credits_full_o),
      .credits_empty_i (cache_req_credits_empty_o),
      .tag_mem_pkt_opcode_o, .tag_mem_pkt_index_o, .tag_mem_pkt_way_o,
      .tag_mem_pkt_tag_o, .tag_mem_pkt_v_o, .tag_mem_pkt_yumi_i,
      .data_mem_pkt_opcode_o, .data_mem_pkt_index_o, .data_mem_pkt_way_o,
      .data_mem_pkt_data_o, .data_mem_pkt_v_o, .data_mem_pkt_yumi_i,
      .mem_cmd_type_o, .mem_cmd_addr_o, .mem_cmd_size_o, .mem_cmd_way_o,
      .mem_cmd_data_o, .mem_cmd_v_o, .mem_cmd_yumi_i,
      .mem_resp_type_i, .mem_resp_addr_i, .mem_resp_way_i, .mem_resp_data_i,
      .mem_resp_v_i, .mem_resp_yumi_o,
      .cmd_fire_o  (cmd_fire),
      .resp_fire_o (resp_fire)
    );

endmodule

/* tests/uce_env_model.sv */
`timescale 1ns/1ps

module uce_env_model
  (
    input  logic                                 clk_i,
    input  logic                                 reset_i,

    input  uce_pkg::mem_msg_e                    mem_cmd_type_i,
    input  logic [uce_pkg::PADDR_WIDTH-1:0]      mem_cmd_addr_i,
    input  logic [uce_pkg::WAY_WIDTH-1:0]        mem_cmd_way_i,
    input  logic                                 mem_cmd_v_i,
    output logic                                 mem_cmd_yumi_o,
    output logic                                 tag_mem_pkt_yumi_o,
    output logic                                 data_mem_pkt_yumi_o,

    output uce_pkg::mem_msg_e                    mem_resp_type_o,
    output logic [uce_pkg::PADDR_WIDTH-1:0]      mem_resp_addr_o,
    output logic [uce_pkg::WAY_WIDTH-1:0]        mem_resp_way_o,
    output logic [uce_pkg::DWORD_WIDTH-1:0]      mem_resp_data_o,
    output logic                                 mem_resp_v_o,
    input  logic                                 mem_resp_yumi_i
  );

  import uce_pkg::*;

  mem_msg_e               type_q[$];
  logic [PADDR_WIDTH-1:0] addr_q[$];
  logic [WAY_WIDTH-1:0]   way_q[$];
  int                     due_q[$];
  int                     cycle;

  // Memory contents are a fixed pattern built from the whole address
  function automatic logic [DWORD_WIDTH-1:0] mem_word(input logic [PADDR_WIDTH-1:0] addr);
    return {12'ha5c, addr, 12'h3e1, ~addr};
  endfunction

  initial
  begin
    mem_cmd_yumi_o      = 1'b0;
    tag_mem_pkt_yumi_o  = 1'b0;
    data_mem_pkt_yumi_o = 1'b0;
    mem_resp_type_o     = e_mem_rd;
    mem_resp_addr_o     = '0;
    mem_resp_way_o      = '0;
    mem_resp_data_o     = '0;
    mem_resp_v_o        = 1'b0;
    cycle               = 0;
  end

  always @(posedge clk_i)
  begin
    int unsigned r;
    r = $urandom();
    // Each accept is stalled about a quarter of the time
    mem_cmd_yumi_o      <= (r[1:0] != 2'b00);
    tag_mem_pkt_yumi_o  <= (r[3:2] != 2'b00);
    data_mem_pkt_yumi_o <= (r[5:4] != 2'b00);
    if (reset_i)
    begin
      type_q.delete();
      addr_q.delete();
      way_q.delete();
      due_q.delete();
      mem_resp_v_o <= 1'b0;
    end
    else
    begin
      cycle = cycle + 1;
      if (mem_resp_v_o && mem_resp_yumi_i)
      begin
        void'(type_q.pop_front());
        void'(addr_q.pop_front());
        void'(way_q.pop_front());
        void'(due_q.pop_front());
      end
      if (mem_cmd_v_i && mem_cmd_yumi_o)
      begin
        type_q.push_back(mem_cmd_type_i);
        addr_q.push_back(mem_cmd_addr_i);
        way_q.push_back(mem_cmd_way_i);
        due_q.push_back(cycle + 1 + int'((r >> 8) % 6));
      end
      if (due_q.size() > 0 && due_q[0] <= cycle)
      begin
        mem_resp_type_o <= type_q[0];
        mem_resp_addr_o <= addr_q[0];
        mem_resp_way_o  <= way_q[0];
        mem_resp_data_o <= (type_q[0] == e_mem_uc_wr) ? '0 : mem_word(addr_q[0]);
        mem_resp_v_o    <= 1'b1;
      end
      else
        mem_resp_v_o <= 1'b0;
    end
  end

endmodule

/* tests/uce_tb.sv */
`timescale 1ns/1ps

module uce_tb;

  import uce_pkg::*;

  localparam int NUM_OPS        = 102;
  localparam int TIMEOUT_CYCLES = 8000;

  typedef struct packed
  {
    mem_msg_e               mtype;
    logic [PADDR_WIDTH-1:0] addr;
    logic [SIZE_WIDTH-1:0]  size;
    logic [WAY_WIDTH-1:0]   way;
    logic [DWORD_WIDTH-1:0] data;
  } cmd_t;

  typedef struct packed
  {
    tag_opcode_e            opcode;
    logic [INDEX_WIDTH-1:0] index;
    logic [WAY_WIDTH-1:0]   way;
    logic [TAG_WIDTH-1:0]   tag;
  } tag_pkt_t;

  typedef struct packed
  {
    data_opcode_e           opcode;
    logic [INDEX_WIDTH-1:0] index;
    logic [WAY_WIDTH-1:0]   way;
    logic [DWORD_WIDTH-1:0] data;
  } data_pkt_t;

  logic clk_i;
  logic reset_i;
  cache_req_type_e cache_req_type_i;
  logic [PADDR_WIDTH-1:0] cache_req_addr_i;
  logic [DWORD_WIDTH-1:0] cache_req_data_i;
  logic [SIZE_WIDTH-1:0] cache_req_size_i;
  logic cache_req_v_i, cache_req_yumi_o, cache_req_busy_o, cache_req_complete_o;
  logic [WAY_WIDTH-1:0] cache_req_metadata_way_i;
  logic cache_req_metadata_v_i, credits_full, credits_empty;
  tag_opcode_e tag_opcode;
  logic [INDEX_WIDTH-1:0] tag_index, data_index;
  logic [WAY_WIDTH-1:0] tag_way, data_way, cmd_way, resp_way;
  logic [TAG_WIDTH-1:0] tag_tag;
  logic tag_v, tag_yumi, data_v, data_yumi;
  data_opcode_e data_opcode;
  logic [DWORD_WIDTH-1:0] data_data, cmd_data, resp_data;
  mem_msg_e cmd_type, resp_type;
  logic [PADDR_WIDTH-1:0] cmd_addr, resp_addr;
  logic [SIZE_WIDTH-1:0] cmd_size;
  logic cmd_v, cmd_yumi, resp_v, resp_yumi;

  cmd_t      exp_cmd_q[$];
  tag_pkt_t  exp_tag_q[$];
  data_pkt_t exp_data_q[$];
  cmd_t      cur_cmd, prev_cmd;
  tag_pkt_t  cur_tag, prev_tag;
  data_pkt_t cur_data, prev_data;
  logic      prev_cmd_hold, prev_tag_hold, prev_data_hold;
  cache_req_type_e cur_type;
  int        completes;
  int        outstanding;
  int        cycles;
  int        failures;

  assign cur_cmd  = {cmd_type, cmd_addr, cmd_size, cmd_way, cmd_data};
  assign cur_tag  = {tag_opcode, tag_index, tag_way, tag_tag};
  assign cur_data = {data_opcode, data_index, data_way, data_data};

  uce_top DUT
    (
      .clk_i, .reset_i,
      .cache_req_type_i, .cache_req_addr_i, .cache_req_data_i, .cache_req_size_i,
      .cache_req_v_i, .cache_req_yumi_o, .cache_req_busy_o, .cache_req_complete_o,
      .cache_req_metadata_way_i, .cache_req_metadata_v_i,
      .cache_req_credits_full_o (credits_full),
      .cache_req_credits_empty_o (credits_empty),
      .tag_mem_pkt_opcode_o (tag_opcode), .tag_mem_pkt_index_o (tag_index),
      .tag_mem_pkt_way_o (tag_way), .tag_mem_pkt_tag_o (tag_tag),
      .tag_mem_pkt_v_o (tag_v), .tag_mem_pkt_yumi_i (tag_yumi),
      .data_mem_pkt_opcode_o (data_opcode), .data_mem_pkt_index_o (data_index),
      .data_mem_pkt_way_o (data_way), .data_mem_pkt_data_o (data_data),
      .data_mem_pkt_v_o (data_v), .data_mem_pkt_yumi_i (data_yumi),
      .mem_cmd_type_o (cmd_type), .mem_cmd_addr_o (cmd_addr), .mem_cmd_size_o (cmd_size),
      .mem_cmd_way_o (cmd_way), .mem_cmd_data_o (cmd_data),
      .mem_cmd_v_o (cmd_v), .mem_cmd_yumi_i (cmd_yumi),
      .mem_resp_type_i (resp_type), .mem_resp_addr_i (resp_addr),
      .mem_resp_way_i (resp_way), .mem_resp_data_i (resp_data),
      .mem_resp_v_i (resp_v), .mem_resp_yumi_o (resp_yumi)
    );

  uce_env_model env
    (
      .clk_i, .reset_i,
      .mem_cmd_type_i (cmd_type), .mem_cmd_addr_i (cmd_addr), .mem_cmd_way_i (cmd_way),
      .mem_cmd_v_i (cmd_v), .mem_cmd_yumi_o (cmd_yumi),
      .tag_mem_pkt_yumi_o (tag_yumi), .data_mem_pkt_yumi_o (data_yumi),
      .mem_resp_type_o (resp_type), .mem_resp_addr_o (resp_addr),
      .mem_resp_way_o (resp_way), .mem_resp_data_o (resp_data),
      .mem_resp_v_o (resp_v), .mem_resp_yumi_i (resp_yumi)
    );

  initial
  begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  task automatic fail_run(input string msg);
    failures = failures + 1;
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [95:0] got, input logic [95:0] exp);
    if (got !== exp)
      fail_run($sformatf("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp));
  endtask

  // Expected memory word from the fixed address pattern of the memory model
  function automatic logic [DWORD_WIDTH-1:0] fill_word(input logic [PADDR_WIDTH-1:0] addr);
    return {12'ha5c, addr, 12'h3e1, ~addr};
  endfunction

  // Queues the expected command and packets of one request in firing order
  function automatic void predict(input cache_req_type_e t, input logic [PADDR_WIDTH-1:0] a,
                                  input logic [SIZE_WIDTH-1:0] s, input logic [DWORD_WIDTH-1:0] d,
                                  input logic [WAY_WIDTH-1:0] w);
    logic [PADDR_WIDTH-1:0] blk;
    blk = {a[PADDR_WIDTH-1:BLOCK_OFFSET_WIDTH], 3'b000};
    if (t == e_miss_load)
    begin
      exp_cmd_q.push_back({e_mem_rd, blk, 2'd3, w, 64'd0});
      exp_tag_q.push_back({e_tag_set_tag, a[6:3], w, a[19:7]});
      exp_data_q.push_back({e_data_write, a[6:3], w, fill_word(blk)});
    end
    else if (t == e_uc_load)
    begin
      exp_cmd_q.push_back({e_mem_uc_rd, a, s, 1'b0, d});
      exp_data_q.push_back({e_data_uncached, a[6:3], 1'b0, fill_word(a)});
    end
    else
      exp_cmd_q.push_back({e_mem_uc_wr, a, s, 1'b0, d});
  endfunction

  function automatic void predict_sweep();
    for (int i = 0; i < SETS; i++)
      exp_tag_q.push_back({e_tag_set_clear, 4'(i), 1'b0, 13'd0});
  endfunction

  task automatic wait_complete();
    do @(posedge clk_i); while (!cache_req_complete_o);
  endtask

  task automatic issue_request();
    int unsigned r;
    int md;
    cache_req_type_e t;
    logic [PADDR_WIDTH-1:0] a;
    logic [DWORD_WIDTH-1:0] d;
    logic [SIZE_WIDTH-1:0] s;
    logic w;
    r = $urandom();
    t = cache_req_type_e'(2'(r % 3));
    r = $urandom();
    a = r[19:0];
    s = r[21:20];
    w = r[22];
    md = int'(r[25:24]);
    d = {$urandom(), $urandom()};
    cur_type <= t;
    cache_req_type_i <= t;
    cache_req_addr_i <= a;
    cache_req_data_i <= d;
    cache_req_size_i <= s;
    cache_req_v_i    <= 1'b1;
    // Metadata held alongside valid lands in the accept cycle
    if (t == e_miss_load && md == 0)
    begin
      cache_req_metadata_way_i <= w;
      cache_req_metadata_v_i   <= 1'b1;
    end
    do @(posedge clk_i); while (!cache_req_yumi_o);
    predict(t, a, s, d, w);
    cache_req_v_i          <= 1'b0;
    cache_req_metadata_v_i <= 1'b0;
    if (t == e_miss_load && md != 0)
    begin
      repeat (md - 1) @(posedge clk_i);
      cache_req_metadata_way_i <= w;
      cache_req_metadata_v_i   <= 1'b1;
      @(posedge clk_i);
      cache_req_metadata_v_i <= 1'b0;
    end
    wait_complete();
  endtask

  task automatic issue_clear();
    cur_type <= e_cache_clear;
    cache_req_type_i <= e_cache_clear;
    cache_req_v_i    <= 1'b1;
    do @(posedge clk_i); while (!cache_req_yumi_o);
    predict_sweep();
    cache_req_v_i <= 1'b0;
    wait_complete();
  endtask

  initial
  begin
    void'($urandom(7511));
    failures = 0;
    completes = 0;
    outstanding = 0;
    cur_type = e_cache_clear;
    reset_i = 1'b1;
    cache_req_type_i = e_miss_load;
    cache_req_addr_i = '0;
    cache_req_data_i = '0;
    cache_req_size_i = '0;
    cache_req_v_i = 1'b0;
    cache_req_metadata_way_i = '0;
    cache_req_metadata_v_i = 1'b0;
    predict_sweep();
    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    wait_complete();
    for (int i = 0; i < NUM_OPS; i++)
    begin
      if (i == 34 || i == 68)
        issue_clear();
      else
        issue_request();
    end
    // Store responses may still be in flight
    do @(posedge clk_i); while (outstanding != 0);
    check("cache_req_credits_empty_o", 96'(credits_empty), 96'(1));
    check("pending expected items", 96'(exp_cmd_q.size() + exp_tag_q.size()
          + exp_data_q.size()), 96'(0));
    check("complete pulse count", 96'(completes), 96'(NUM_OPS + 1));
    if (failures == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      if (cmd_v && credits_full)
        fail_run("A memory command was offered while the credits were full");
      if (prev_cmd_hold)
        check("mem_cmd held fields", 96'({cmd_v, cur_cmd}), 96'({1'b1, prev_cmd}));
      if (prev_tag_hold)
        check("tag_mem_pkt held fields", 96'({tag_v, cur_tag}), 96'({1'b1, prev_tag}));
      if (prev_data_hold)
        check("data_mem_pkt held fields", 96'({data_v, cur_data}), 96'({1'b1, prev_data}));
      if (cmd_v && cmd_yumi)
      begin
        if (exp_cmd_q.size() == 0)
          fail_run("A memory command fired with none expected");
        check("mem_cmd", 96'(cur_cmd), 96'(exp_cmd_q.pop_front()));
      end
      if (tag_v && tag_yumi)
      begin
        if (exp_tag_q.size() == 0)
          fail_run("A tag packet fired with none expected");
        check("tag_mem_pkt", 96'(cur_tag), 96'(exp_tag_q.pop_front()));
      end
      if (data_v && data_yumi)
      begin
        if (exp_data_q.size() == 0)
          fail_run("A data packet fired with none expected");
        check("data_mem_pkt", 96'(cur_data), 96'(exp_data_q.pop_front()));
      end
      if (tag_v && tag_opcode == e_tag_set_clear)
        check("cache_req_busy_o", 96'(cache_req_busy_o), 96'(1));
      if (resp_v && resp_type == e_mem_uc_wr)
        check("mem_resp_yumi_o", 96'(resp_yumi), 96'(1));
      if (cache_req_complete_o && cur_type == e_uc_store)
        check("store complete with mem_cmd fire", 96'(cmd_v && cmd_yumi), 96'(1));
      if (cache_req_complete_o && cur_type == e_uc_load)
        check("load complete with data fire", 96'(data_v && data_yumi), 96'(1));
      // A fill or a sweep completes with its last packet and leaves nothing expected
      if (cache_req_complete_o && (cur_type == e_miss_load || cur_type == e_cache_clear))
        check("complete with last tag or data fire",
              96'({(tag_v && tag_yumi) || (data_v && data_yumi),
                   exp_tag_q.size() == 0, exp_data_q.size() == 0}), 96'(3'b111));
      if (cache_req_complete_o)
        completes = completes + 1;
      outstanding <= outstanding + int'(cmd_v && cmd_yumi) - int'(resp_v && resp_yumi);
    end
    prev_cmd_hold  <= cmd_v & ~cmd_yumi & ~reset_i;
    prev_tag_hold  <= tag_v & ~tag_yumi & ~reset_i;
    prev_data_hold <= data_v & ~data_yumi & ~reset_i;
    prev_cmd  <= cur_cmd;
    prev_tag  <= cur_tag;
    prev_data <= cur_data;
  end

  initial
    cycles = 0;

  always @(posedge clk_i)
  begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES)
      fail_run($sformatf("Timeout after %0d cycles before the requests finished", cycles));
  end

endmodule

/* files.f */
logic/uce_pkg.sv
logic/uce_req_regs.sv
logic/uce_credit_tracker.sv
logic/uce_fsm.sv
logic/uce_top.sv
tests/uce_env_model.sv
tests/uce_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the uce testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module uce_tb -f files.f -o uce_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see build.log"
  exit 1
fi

./obj_dir/uce_sim > sim.log 2>&1
status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if ! grep -q "TEST PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi

exit 0
